//--- hdl/qbu_cfg.svh
`ifndef QBU_CFG_SVH
`define QBU_CFG_SVH

// ---------------------------------------------------------------------------
// register bus geometry
// ---------------------------------------------------------------------------

// byte wide register address
`define QBU_ADDR_W 8

// read and write data width
`define QBU_DATA_W 16

// ---------------------------------------------------------------------------
// reset values of the writable fields
// ---------------------------------------------------------------------------

// verification on by default
`define QBU_DEF_VERIFY_EN 1'b1

// smallest legal mPacket fragment in bytes
`define QBU_DEF_MIN_FRAG 8'd46

// verify retry interval
`define QBU_DEF_VERIFY_TIMER 8'd10

// inter packet gap in byte times
`define QBU_DEF_IPG_TIMER 8'd12

// 24 bit watchdog split over 0x13 (low 16) and 0x14 (high 8)
`define QBU_DEF_WDOG 24'h01E848

`endif

//--- hdl/qbu_pkg.sv
`include "qbu_cfg.svh"

package qbu_pkg;

    // ------------------------------------------------------------------------
    // register address map
    // ------------------------------------------------------------------------
    // 0x10..0x12 and 0x16..0x18 left out of the map and read as zero
    typedef enum logic [`QBU_ADDR_W-1:0] {
        addr_preempt_en    = 8'h00,
        addr_verify_en     = 8'h01,
        addr_busy          = 8'h02,
        addr_tx_frag_cnt   = 8'h03,
        addr_rx_frag_cnt   = 8'h04,
        addr_frag_mismatch = 8'h05,
        addr_preempt_state = 8'h06,
        addr_err_rx_crc    = 8'h07,
        addr_err_rx_frame  = 8'h08,
        addr_err_fragment  = 8'h09,
        addr_err_verify    = 8'h0A,
        addr_min_frag_size = 8'h0B,
        addr_verify_timer  = 8'h0C,
        addr_ipg_timer     = 8'h0D,
        addr_reset_ctrl    = 8'h0E,
        addr_verify_ctrl   = 8'h0F,
        addr_wdog_lo       = 8'h13,
        addr_wdog_hi       = 8'h14,
        addr_tx_timeout    = 8'h15
    } qbu_addr_e;

    // one bus cycle without handshake
    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [`QBU_ADDR_W-1:0] addr;
        logic [`QBU_DATA_W-1:0] wdata;
    } qbu_bus_req_t;

    // ------------------------------------------------------------------------
    // mac side groups
    // ------------------------------------------------------------------------
    // status and counters sampled from the mac
    typedef struct packed {
        logic        preempt_en;
        logic        rx_busy;
        logic        tx_busy;
        logic        preemptable_frame;
        logic        preempt_active;
        logic [15:0] tx_frag_cnt;
        logic [15:0] rx_frag_cnt;
        logic        frag_mismatch;
        logic [15:0] err_rx_crc_cnt;
        logic [15:0] err_rx_frame_cnt;
        logic [15:0] err_fragment_cnt;
        logic [15:0] err_verify_cnt;
        logic        tx_timeout;
    } qbu_status_t;

    // writable configuration values
    typedef struct packed {
        logic        verify_en;
        logic [7:0]  min_frag_size;
        logic [7:0]  verify_timer;
        logic [7:0]  ipg_timer;
        logic [23:0] watchdog;
    } qbu_cfg_t;

    // update strobes for all fields but verify enable
    typedef struct packed {
        logic min_frag_size;
        logic verify_timer;
        logic ipg_timer;
        logic watchdog;
    } qbu_cfg_valid_t;

    // self clearing control strobes
    typedef struct packed {
        logic reset;
        logic start_verify;
        logic clear_verify;
    } qbu_ctrl_t;

endpackage

//--- hdl/qbu_cfg_regs.sv
`timescale 1ns/1ns

`include "qbu_cfg.svh"

module qbu_cfg_regs (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  qbu_pkg::qbu_bus_req_t  i_bus_req,
    output qbu_pkg::qbu_cfg_t      o_cfg,
    output qbu_pkg::qbu_cfg_valid_t o_cfg_valid,
    output qbu_pkg::qbu_ctrl_t     o_ctrl
);

    // ------------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------------
    // configuration fields held until rewritten
    qbu_pkg::qbu_cfg_t       cfg_q;
    // per field update strobes
    qbu_pkg::qbu_cfg_valid_t cfg_valid_q;
    // reset / verify control strobes
    qbu_pkg::qbu_ctrl_t      ctrl_q;

    // address seen through the map
    qbu_pkg::qbu_addr_e      wr_addr;

    assign wr_addr = qbu_pkg::qbu_addr_e'(i_bus_req.addr);

    // ------------------------------------------------------------------------
    // configuration fields
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            // come up with the mac defaults
            cfg_q.verify_en     <= `QBU_DEF_VERIFY_EN;
            cfg_q.min_frag_size <= `QBU_DEF_MIN_FRAG;
            cfg_q.verify_timer  <= `QBU_DEF_VERIFY_TIMER;
            cfg_q.ipg_timer     <= `QBU_DEF_IPG_TIMER;
            cfg_q.watchdog      <= `QBU_DEF_WDOG;
        end else if (i_bus_req.wr) begin
            case (wr_addr)
                qbu_pkg::addr_verify_en: begin
                    cfg_q.verify_en <= i_bus_req.wdata[0];
                end
                qbu_pkg::addr_min_frag_size: begin
                    cfg_q.min_frag_size <= i_bus_req.wdata[7:0];
                end
                qbu_pkg::addr_verify_timer: begin
                    cfg_q.verify_timer <= i_bus_req.wdata[7:0];
                end
                qbu_pkg::addr_ipg_timer: begin
                    cfg_q.ipg_timer <= i_bus_req.wdata[7:0];
                end
                // full data word lands in the low half
                qbu_pkg::addr_wdog_lo: begin
                    cfg_q.watchdog[15:0] <= i_bus_req.wdata;
                end
                // only the low byte is meaningful here
                qbu_pkg::addr_wdog_hi: begin
                    cfg_q.watchdog[23:16] <= i_bus_req.wdata[7:0];
                end
                // status, control and unmapped addresses
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // one cycle strobes
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cfg_valid_q <= '0;
            ctrl_q      <= '0;
        end else begin
            // low unless this edge carries a write
            cfg_valid_q <= '0;
            ctrl_q      <= '0;
            if (i_bus_req.wr) begin
                case (wr_addr)
                    qbu_pkg::addr_min_frag_size: begin
                        cfg_valid_q.min_frag_size <= 1'b1;
                    end
                    qbu_pkg::addr_verify_timer: begin
                        cfg_valid_q.verify_timer <= 1'b1;
                    end
                    qbu_pkg::addr_ipg_timer: begin
                        cfg_valid_q.ipg_timer <= 1'b1;
                    end
                    // watchdog commits on the low half write
                    qbu_pkg::addr_wdog_lo: begin
                        cfg_valid_q.watchdog <= 1'b1;
                    end
                    // bit 0 requests a mac reset
                    qbu_pkg::addr_reset_ctrl: begin
                        ctrl_q.reset <= i_bus_req.wdata[0];
                    end
                    // bit 0 clear and bit 1 start
                    qbu_pkg::addr_verify_ctrl: begin
                        ctrl_q.clear_verify <= i_bus_req.wdata[0];
                        ctrl_q.start_verify <= i_bus_req.wdata[1];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign o_cfg       = cfg_q;
    assign o_cfg_valid = cfg_valid_q;
    assign o_ctrl      = ctrl_q;

endmodule

//--- hdl/qbu_read_port.sv
`timescale 1ns/1ns

`include "qbu_cfg.svh"

module qbu_read_port (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  qbu_pkg::qbu_bus_req_t  i_bus_req,
    input  qbu_pkg::qbu_status_t   i_status,
    input  qbu_pkg::qbu_cfg_t      i_cfg,
    output logic [`QBU_DATA_W-1:0] o_bus_dout
);

    // ------------------------------------------------------------------------
    // status capture
    // ------------------------------------------------------------------------
    // mac status sampled once per clock
    qbu_pkg::qbu_status_t     status_q;
    // address seen through the map
    qbu_pkg::qbu_addr_e       rd_addr;
    // selected field before the output flop
    logic [`QBU_DATA_W-1:0]   rd_data;
    // registered read data
    logic [`QBU_DATA_W-1:0]   dout_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            status_q <= '0;
        end else begin
            status_q <= i_status;
        end
    end

    assign rd_addr = qbu_pkg::qbu_addr_e'(i_bus_req.addr);

    // ------------------------------------------------------------------------
    // read select
    // ------------------------------------------------------------------------
    // every field zero extended to the bus width
    always_comb begin
        case (rd_addr)
            qbu_pkg::addr_preempt_en:    rd_data = `QBU_DATA_W'(status_q.preempt_en);
            qbu_pkg::addr_verify_en:     rd_data = `QBU_DATA_W'(i_cfg.verify_en);
            // rx in bit 1 and tx in bit 0
            qbu_pkg::addr_busy: begin
                rd_data = `QBU_DATA_W'({status_q.rx_busy, status_q.tx_busy});
            end
            qbu_pkg::addr_tx_frag_cnt:   rd_data = status_q.tx_frag_cnt;
            qbu_pkg::addr_rx_frag_cnt:   rd_data = status_q.rx_frag_cnt;
            qbu_pkg::addr_frag_mismatch: rd_data = `QBU_DATA_W'(status_q.frag_mismatch);
            // preemptable frame above preempt active
            qbu_pkg::addr_preempt_state: begin
                rd_data = `QBU_DATA_W'({status_q.preemptable_frame,
                                        status_q.preempt_active});
            end
            // error counters
            qbu_pkg::addr_err_rx_crc:    rd_data = status_q.err_rx_crc_cnt;
            qbu_pkg::addr_err_rx_frame:  rd_data = status_q.err_rx_frame_cnt;
            qbu_pkg::addr_err_fragment:  rd_data = status_q.err_fragment_cnt;
            qbu_pkg::addr_err_verify:    rd_data = status_q.err_verify_cnt;
            // configuration readback
            qbu_pkg::addr_min_frag_size: rd_data = `QBU_DATA_W'(i_cfg.min_frag_size);
            qbu_pkg::addr_verify_timer:  rd_data = `QBU_DATA_W'(i_cfg.verify_timer);
            qbu_pkg::addr_ipg_timer:     rd_data = `QBU_DATA_W'(i_cfg.ipg_timer);
            qbu_pkg::addr_wdog_lo:       rd_data = i_cfg.watchdog[15:0];
            qbu_pkg::addr_wdog_hi:       rd_data = `QBU_DATA_W'(i_cfg.watchdog[23:16]);
            qbu_pkg::addr_tx_timeout:    rd_data = `QBU_DATA_W'(status_q.tx_timeout);
            // control strobes, dropped debug and frame control registers and holes
            default:                     rd_data = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // output flop
    // ------------------------------------------------------------------------
    // data one cycle after the strobe and zero on idle cycles
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dout_q <= '0;
        end else if (i_bus_req.rd) begin
            dout_q <= rd_data;
        end else begin
            dout_q <= '0;
        end
    end

    assign o_bus_dout = dout_q;

endmodule

//--- hdl/qbu_reg_list.sv
`timescale 1ns/1ns

`include "qbu_cfg.svh"

module qbu_reg_list (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  qbu_pkg::qbu_bus_req_t   i_bus_req,
    input  qbu_pkg::qbu_status_t    i_status,
    output logic [`QBU_DATA_W-1:0]  o_bus_dout,
    output qbu_pkg::qbu_cfg_t       o_cfg,
    output qbu_pkg::qbu_cfg_valid_t o_cfg_valid,
    output qbu_pkg::qbu_ctrl_t      o_ctrl
);

    // ------------------------------------------------------------------------
    // internal wiring
    // ------------------------------------------------------------------------
    // config values shared by the mac and the readback path
    qbu_pkg::qbu_cfg_t cfg;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    // decodes writes into fields and strobes
    qbu_cfg_regs cfg_regs_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_bus_req   (i_bus_req),
        .o_cfg       (cfg),
        .o_cfg_valid (o_cfg_valid),
        .o_ctrl      (o_ctrl)
    );

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    // same bus request, status capture and read mux
    qbu_read_port read_port_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_bus_req  (i_bus_req),
        .i_status   (i_status),
        .i_cfg      (cfg),
        .o_bus_dout (o_bus_dout)
    );

    // config also leaves the block
    assign o_cfg = cfg;

endmodule

//--- verification/qbu_tests.svh
`ifndef QBU_TESTS_SVH
`define QBU_TESTS_SVH

// ----------------------------------------------------------------------------
// bus access and reference model
// ----------------------------------------------------------------------------
// write strobe for one edge before going back to idle
task automatic write_reg(input logic [`QBU_ADDR_W-1:0] addr,
                         input logic [`QBU_DATA_W-1:0] data);
    @(posedge clk);
    bus_req.wr    <= 1'b1;
    bus_req.rd    <= 1'b0;
    bus_req.addr  <= addr;
    bus_req.wdata <= data;
    @(posedge clk);
    bus_req.wr <= 1'b0;
endtask

// data shows up one cycle after the strobe edge
task automatic read_reg(input logic [`QBU_ADDR_W-1:0] addr,
                        output logic [`QBU_DATA_W-1:0] data);
    @(posedge clk);
    bus_req.rd   <= 1'b1;
    bus_req.addr <= addr;
    @(posedge clk);
    bus_req.rd <= 1'b0;
    @(negedge clk);
    data = bus_dout;
endtask

// register map as seen from the bus with zero extension
function automatic logic [`QBU_DATA_W-1:0] expected_read(input logic [7:0] addr);
    case (addr)
        8'h00: return {15'd0, exp_status.preempt_en};
        8'h01: return {15'd0, exp_cfg.verify_en};
        8'h02: return {14'd0, exp_status.rx_busy, exp_status.tx_busy};
        8'h03: return exp_status.tx_frag_cnt;
        8'h04: return exp_status.rx_frag_cnt;
        8'h05: return {15'd0, exp_status.frag_mismatch};
        8'h06: return {14'd0, exp_status.preemptable_frame, exp_status.preempt_active};
        8'h07: return exp_status.err_rx_crc_cnt;
        8'h08: return exp_status.err_rx_frame_cnt;
        8'h09: return exp_status.err_fragment_cnt;
        8'h0A: return exp_status.err_verify_cnt;
        8'h0B: return {8'd0, exp_cfg.min_frag_size};
        8'h0C: return {8'd0, exp_cfg.verify_timer};
        8'h0D: return {8'd0, exp_cfg.ipg_timer};
        8'h13: return exp_cfg.watchdog[15:0];
        8'h14: return {8'd0, exp_cfg.watchdog[23:16]};
        8'h15: return {15'd0, exp_status.tx_timeout};
        // control, dropped and unmapped addresses
        default: return '0;
    endcase
endfunction

task automatic read_and_compare(input logic [7:0] addr);
    logic [`QBU_DATA_W-1:0] data;
    read_reg(addr, data);
    compare_value($sformatf("o_bus_dout at 0x%02h", addr), data, expected_read(addr));
endtask

// configuration addresses in map order
function automatic logic [7:0] cfg_addr(input int idx);
    case (idx)
        0: return 8'h01;
        1: return 8'h0B;
        2: return 8'h0C;
        3: return 8'h0D;
        4: return 8'h13;
        default: return 8'h14;
    endcase
endfunction

// anything that changes a field or fires a control strobe
function automatic bit takes_writes(input logic [7:0] addr);
    case (addr)
        8'h01, 8'h0B, 8'h0C, 8'h0D, 8'h0E, 8'h0F, 8'h13, 8'h14: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

task automatic model_write(input logic [7:0] addr, input logic [15:0] data);
    case (addr)
        8'h01: exp_cfg.verify_en = data[0];
        8'h0B: exp_cfg.min_frag_size = data[7:0];
        8'h0C: exp_cfg.verify_timer = data[7:0];
        8'h0D: exp_cfg.ipg_timer = data[7:0];
        8'h13: exp_cfg.watchdog[15:0] = data;
        8'h14: exp_cfg.watchdog[23:16] = data[7:0];
        default: ;
    endcase
endtask

// verify enable and watchdog high carry no strobe
function automatic qbu_pkg::qbu_cfg_valid_t expected_valid(input logic [7:0] addr);
    qbu_pkg::qbu_cfg_valid_t v;
    v = '0;
    case (addr)
        8'h0B: v.min_frag_size = 1'b1;
        8'h0C: v.verify_timer = 1'b1;
        8'h0D: v.ipg_timer = 1'b1;
        8'h13: v.watchdog = 1'b1;
        default: ;
    endcase
    return v;
endfunction

function automatic qbu_pkg::qbu_status_t random_status();
    logic [127:0] raw;
    raw = {$urandom(), $urandom(), $urandom(), $urandom()};
    return qbu_pkg::qbu_status_t'(raw[$bits(qbu_pkg::qbu_status_t)-1:0]);
endfunction

task automatic compare_cfg();
    compare_value("o_cfg.verify_en", cfg.verify_en, exp_cfg.verify_en);
    compare_value("o_cfg.min_frag_size", cfg.min_frag_size, exp_cfg.min_frag_size);
    compare_value("o_cfg.verify_timer", cfg.verify_timer, exp_cfg.verify_timer);
    compare_value("o_cfg.ipg_timer", cfg.ipg_timer, exp_cfg.ipg_timer);
    compare_value("o_cfg.watchdog", cfg.watchdog, exp_cfg.watchdog);
endtask

// ----------------------------------------------------------------------------
// strobe checks
// ----------------------------------------------------------------------------
// first strobe after the write edge has to drop again a cycle later
task automatic await_pulse(input qbu_pkg::qbu_cfg_valid_t want_valid,
                           input qbu_pkg::qbu_ctrl_t want_ctrl);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < PULSE_TIMEOUT) begin
        @(negedge clk);
        cycles++;
        seen = (cfg_valid != '0) || (ctrl != '0);
    end
    if (!seen) begin
        errors++;
        $display("Timeout at %0t ns: no valid or control pulse within %0d cycles of a write",
                 $time, PULSE_TIMEOUT);
    end else begin
        compare_value("pulse latency in cycles", cycles, 1);
        compare_value("o_cfg_valid", cfg_valid, want_valid);
        compare_value("o_ctrl", ctrl, want_ctrl);
        @(negedge clk);
        compare_value("o_cfg_valid after pulse", cfg_valid, '0);
        compare_value("o_ctrl after pulse", ctrl, '0);
    end
endtask

task automatic confirm_no_pulse();
    @(negedge clk);
    compare_value("o_cfg_valid", cfg_valid, '0);
    compare_value("o_ctrl", ctrl, '0);
endtask

task automatic report_test(input string name, input int errors_before);
    $display("%s finished with %0d errors", name, errors - errors_before);
endtask

// ----------------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------------
task automatic reset_defaults();
    int errors_before;
    int idx;
    errors_before = errors;
    compare_value("o_cfg.verify_en", cfg.verify_en, `QBU_DEF_VERIFY_EN);
    compare_value("o_cfg.min_frag_size", cfg.min_frag_size, `QBU_DEF_MIN_FRAG);
    compare_value("o_cfg.verify_timer", cfg.verify_timer, `QBU_DEF_VERIFY_TIMER);
    compare_value("o_cfg.ipg_timer", cfg.ipg_timer, `QBU_DEF_IPG_TIMER);
    compare_value("o_cfg.watchdog", cfg.watchdog, `QBU_DEF_WDOG);
    compare_value("o_cfg_valid", cfg_valid, '0);
    compare_value("o_ctrl", ctrl, '0);
    compare_value("o_bus_dout", bus_dout, '0);
    for (idx = 0; idx < 6; idx++) begin
        read_and_compare(cfg_addr(idx));
    end
    report_test("reset defaults", errors_before);
endtask

task automatic config_writes();
    int errors_before;
    int round;
    int idx;
    logic [7:0] addr;
    logic [15:0] data;
    errors_before = errors;
    for (round = 0; round < 3; round++) begin
        for (idx = 0; idx < 6; idx++) begin
            addr = cfg_addr(idx);
            data = 16'($urandom());
            model_write(addr, data);
            write_reg(addr, data);
            if (expected_valid(addr) != '0) begin
                await_pulse(expected_valid(addr), '0);
            end else begin
                confirm_no_pulse();
            end
            compare_cfg();
            read_and_compare(addr);
        end
    end
    report_test("configuration writes", errors_before);
endtask

task automatic control_pulses();
    int errors_before;
    qbu_pkg::qbu_ctrl_t want;
    errors_before = errors;
    // reset request with random upper bits
    want       = '0;
    want.reset = 1'b1;
    write_reg(8'h0E, 16'($urandom()) | 16'h0001);
    await_pulse('0, want);
    // start and clear together
    want              = '0;
    want.start_verify = 1'b1;
    want.clear_verify = 1'b1;
    write_reg(8'h0F, 16'($urandom()) | 16'h0003);
    await_pulse('0, want);
    compare_cfg();
    read_and_compare(8'h0E);
    read_and_compare(8'h0F);
    report_test("control pulses", errors_before);
endtask

task automatic status_readback();
    int errors_before;
    int round;
    int a;
    errors_before = errors;
    for (round = 0; round < 4; round++) begin
        exp_status = random_status();
        @(posedge clk);
        status <= exp_status;
        // status goes through its capture flop first
        repeat (2) @(posedge clk);
        for (a = 0; a <= 8'h0A; a++) begin
            read_and_compare(8'(a));
        end
        read_and_compare(8'h15);
    end
    report_test("status readback", errors_before);
endtask

task automatic unmapped_accesses();
    int errors_before;
    int a;
    errors_before = errors;
    // dropped debug and frame control registers
    for (a = 8'h10; a <= 8'h18; a++) begin
        if (a < 8'h13 || a > 8'h15) begin
            read_and_compare(8'(a));
        end
    end
    read_and_compare(8'hFF);
    // status, dropped and unmapped writes leave the fields alone
    for (a = 0; a <= 8'h18; a++) begin
        if (!takes_writes(8'(a))) begin
            write_reg(8'(a), 16'($urandom()));
            confirm_no_pulse();
            compare_cfg();
        end
    end
    write_reg(8'hFF, 16'($urandom()));
    confirm_no_pulse();
    compare_cfg();
    // read followed by an idle cycle with the address still on the bus
    @(posedge clk);
    bus_req.rd   <= 1'b1;
    bus_req.addr <= 8'h13;
    @(posedge clk);
    bus_req.rd <= 1'b0;
    @(negedge clk);
    compare_value("o_bus_dout at 0x13", bus_dout, expected_read(8'h13));
    @(negedge clk);
    compare_value("o_bus_dout after idle cycle", bus_dout, '0);
    report_test("unmapped and idle accesses", errors_before);
endtask

`endif

//--- verification/tb_qbu_reg_list.sv
`timescale 1ns/1ns

`include "qbu_cfg.svh"

module tb_qbu_reg_list;

    // ------------------------------------------------------------------------
    // signals
    // ------------------------------------------------------------------------
    // cycles allowed before a missing strobe counts as lost
    localparam int PULSE_TIMEOUT = 8;

    logic                    clk;
    logic                    rst_n;
    // register bus and mac status into the dut
    qbu_pkg::qbu_bus_req_t   bus_req;
    qbu_pkg::qbu_status_t    status;
    // dut outputs
    logic [`QBU_DATA_W-1:0]  bus_dout;
    qbu_pkg::qbu_cfg_t       cfg;
    qbu_pkg::qbu_cfg_valid_t cfg_valid;
    qbu_pkg::qbu_ctrl_t      ctrl;

    // reference copy of what the registers should hold
    qbu_pkg::qbu_cfg_t       exp_cfg;
    qbu_pkg::qbu_status_t    exp_status;

    int checks;
    int errors;

    qbu_reg_list dut_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_bus_req   (bus_req),
        .i_status    (status),
        .o_bus_dout  (bus_dout),
        .o_cfg       (cfg),
        .o_cfg_valid (cfg_valid),
        .o_ctrl      (ctrl)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // compares one value against its expectation
    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    `include "qbu_tests.svh"

    // ------------------------------------------------------------------------
    // run
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h1717));
        checks    = 0;
        errors    = 0;
        rst_n   <= 1'b0;
        bus_req <= '0;
        status  <= '0;
        // model starts from the reset values
        exp_cfg.verify_en     = `QBU_DEF_VERIFY_EN;
        exp_cfg.min_frag_size = `QBU_DEF_MIN_FRAG;
        exp_cfg.verify_timer  = `QBU_DEF_VERIFY_TIMER;
        exp_cfg.ipg_timer     = `QBU_DEF_IPG_TIMER;
        exp_cfg.watchdog      = `QBU_DEF_WDOG;
        exp_status            = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        reset_defaults();
        config_writes();
        control_pulses();
        status_readback();
        unmapped_accesses();
        $display("%0d checks run, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hdl
+incdir+verification
hdl/qbu_pkg.sv
hdl/qbu_cfg_regs.sv
hdl/qbu_read_port.sv
hdl/qbu_reg_list.sv
verification/tb_qbu_reg_list.sv

//--- Bender.yml
package:
  name: qbu_reg_list

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/qbu_pkg.sv
      - hdl/qbu_cfg_regs.sv
      - hdl/qbu_read_port.sv
      - hdl/qbu_reg_list.sv
  - target: test
    include_dirs:
      - hdl
      - verification
    files:
      - verification/tb_qbu_reg_list.sv
